//--- common/cnn_pkg.sv
package cnn_pkg;

	// --------------------
	// Frame geometry
	// --------------------
	localparam int FRAME_W    = 16;
	localparam int FRAME_H    = 16;
	localparam int FRAME_SIZE = FRAME_W * FRAME_H;
	// 3x3 window
	localparam int N_TAPS     = 9;

	// --------------------
	// Data types
	// --------------------
	typedef logic [7:0]         pix_t;
	// Row and column packed as {row, col}
	typedef logic [7:0]         pix_addr_t;
	typedef logic [3:0]         coord_t;
	typedef logic [3:0]         tap_idx_t;
	typedef logic signed [7:0]  weight_t;
	typedef logic signed [15:0] bias_t;
	typedef logic [4:0]         shift_t;
	// Wide enough for nine 8x8 products plus bias
	typedef logic signed [23:0] acc_t;
	typedef logic [3:0]         cfg_addr_t;

	// --------------------
	// Register map
	// --------------------
	// Weights 0..8 at consecutive addresses
	localparam cfg_addr_t REG_WEIGHT0 = 4'd0;
	localparam cfg_addr_t REG_BIAS    = 4'd9;
	// Shift in bits 4:0, activation in bit 8
	localparam cfg_addr_t REG_LAYER   = 4'd10;
	// Any write starts a layer
	localparam cfg_addr_t REG_START   = 4'd11;

	typedef enum logic {
		ACT_RELU   = 1'b0,
		ACT_LINEAR = 1'b1
	} act_e;

	// Layer configuration seen by the MAC
	typedef struct packed {
		weight_t [N_TAPS-1:0] weight;
		bias_t                bias;
		shift_t               shift;
		act_e                 act;
	} layer_cfg_t;

	// One tap read issued by the scanner
	typedef struct packed {
		logic      vld;
		logic      pad;
		logic      first;
		logic      last;
		pix_addr_t addr;
	} tap_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_TAPS,
		SCAN_HOLD
	} scan_state_e;

endpackage

//--- design/cfg_regs.sv
`timescale 1ns/10ps

module cfg_regs
	import cnn_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  logic        cfg_we_i,
	input  cfg_addr_t   cfg_addr_i,
	input  logic [31:0] cfg_wdata_i,
	output layer_cfg_t  layer_cfg_o,
	output logic        start_o
);

	layer_cfg_t cfg_q;
	logic       start_q;
	// Offset into the weight bank
	cfg_addr_t  wt_idx;

	assign wt_idx = cfg_addr_i - REG_WEIGHT0;

	// --------------------
	// Write decode
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			// Zero weights and bias, no shift, ReLU
			cfg_q <= '0;
		end else if (cfg_we_i) begin
			if (wt_idx < N_TAPS) begin
				cfg_q.weight[wt_idx] <= cfg_wdata_i[7:0];
			end else begin
				case (cfg_addr_i)
					REG_BIAS: begin
						cfg_q.bias <= cfg_wdata_i[15:0];
					end
					REG_LAYER: begin
						cfg_q.shift <= cfg_wdata_i[4:0];
						cfg_q.act   <= act_e'(cfg_wdata_i[8]);
					end
					default: begin
						cfg_q <= cfg_q;
					end
				endcase
			end
		end
	end

	// --------------------
	// Start strobe
	// --------------------
	// Single cycle, data bits ignored
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			start_q <= 1'b0;
		end else begin
			start_q <= cfg_we_i && (cfg_addr_i == REG_START);
		end
	end

	assign layer_cfg_o = cfg_q;
	assign start_o     = start_q;

endmodule

//--- design/pixel_loader.sv
`timescale 1ns/10ps

module pixel_loader
	import cnn_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	// Four-phase receiver side
	input  logic      pix_req_i,
	input  pix_t      pix_data_i,
	output logic      pix_ack_o,
	// Frame buffer write port
	output logic      wr_en_o,
	output pix_addr_t wr_addr_o,
	output pix_t      wr_data_o
);

	typedef enum logic {
		LD_IDLE,
		LD_ACK
	} ld_state_e;

	ld_state_e state_q;
	pix_addr_t addr_q;
	logic      take;

	// New request seen while idle
	assign take = (state_q == LD_IDLE) && pix_req_i;

	// --------------------
	// Handshake FSM
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= LD_IDLE;
		end else begin
			case (state_q)
				LD_IDLE: begin
					if (pix_req_i)
						state_q <= LD_ACK;
				end
				// Hold ack until source drops req
				LD_ACK: begin
					if (!pix_req_i)
						state_q <= LD_IDLE;
				end
				default: begin
					state_q <= LD_IDLE;
				end
			endcase
		end
	end

	// Raster write address, wraps per frame
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			addr_q <= '0;
		end else if (take) begin
			if (addr_q == pix_addr_t'(FRAME_SIZE - 1))
				addr_q <= '0;
			else
				addr_q <= addr_q + 1'b1;
		end
	end

	assign pix_ack_o = (state_q == LD_ACK);
	// Pixel written in the cycle req is seen
	assign wr_en_o   = take;
	assign wr_addr_o = addr_q;
	assign wr_data_o = pix_data_i;

endmodule

//--- design/frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer
	import cnn_pkg::*;
(
	input  logic      clk,
	// Write port from the loader
	input  logic      wr_en_i,
	input  pix_addr_t wr_addr_i,
	input  pix_t      wr_data_i,
	// Read port from the scanner
	input  pix_addr_t rd_addr_i,
	output pix_t      rd_data_o
);

	// One full frame, raster order
	pix_t mem [FRAME_SIZE];
	pix_t rd_q;

	// --------------------
	// Write side
	// --------------------
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// --------------------
	// Read side
	// --------------------
	// Registered read, data one cycle after address
	// Reads every cycle, unused data is ignored downstream
	always_ff @(posedge clk) begin
		rd_q <= mem[rd_addr_i];
	end

	assign rd_data_o = rd_q;

endmodule

//--- conv/window_scanner.sv
`timescale 1ns/10ps

module window_scanner
	import cnn_pkg::*;
(
	input  logic      clk,
	input  logic      rstn,
	input  logic      start_i,
	input  logic      mac_busy_i,
	// Output handshake finished
	input  logic      done_i,
	output pix_addr_t rd_addr_o,
	output tap_t      tap_o,
	output logic      layer_done_o
);

	scan_state_e state_q;
	coord_t      row_q;
	coord_t      col_q;
	tap_idx_t    tap_q;
	pix_addr_t   done_cnt_q;
	logic        layer_done_q;
	tap_t        tap_q_d;
	tap_t        tap_now;
	logic        first_row, last_row, first_col, last_col;
	logic        pad_row, pad_col;
	coord_t      nb_row, nb_col;
	logic        stall;

	// Boundary flags of the centre pixel
	assign first_row = (row_q == '0);
	assign last_row  = (row_q == coord_t'(FRAME_H - 1));
	assign first_col = (col_q == '0);
	assign last_col  = (col_q == coord_t'(FRAME_W - 1));

	// MAC full, do not open a new window
	assign stall = (tap_q == '0) && mac_busy_i;

	// --------------------
	// Neighbour address
	// --------------------
	always_comb begin
		nb_row  = row_q;
		nb_col  = col_q;
		pad_row = 1'b0;
		pad_col = 1'b0;
		// Top and bottom rows of the window
		case (tap_q)
			4'd0, 4'd1, 4'd2: begin
				nb_row  = row_q - 1'b1;
				pad_row = first_row;
			end
			4'd6, 4'd7, 4'd8: begin
				nb_row  = row_q + 1'b1;
				pad_row = last_row;
			end
			default: ;
		endcase
		// Left and right columns
		case (tap_q)
			4'd0, 4'd3, 4'd6: begin
				nb_col  = col_q - 1'b1;
				pad_col = first_col;
			end
			4'd2, 4'd5, 4'd8: begin
				nb_col  = col_q + 1'b1;
				pad_col = last_col;
			end
			default: ;
		endcase
		tap_now.vld   = (state_q == SCAN_TAPS) && !stall;
		tap_now.pad   = pad_row || pad_col;
		tap_now.first = (tap_q == '0);
		tap_now.last  = (tap_q == tap_idx_t'(N_TAPS - 1));
		// Padded taps just reread the centre
		tap_now.addr  = tap_now.pad ? {row_q, col_q} : {nb_row, nb_col};
	end

	// --------------------
	// Scan FSM and counters
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= SCAN_IDLE;
			row_q   <= '0;
			col_q   <= '0;
			tap_q   <= '0;
		end else if (start_i) begin
			state_q <= SCAN_TAPS;
			row_q   <= '0;
			col_q   <= '0;
			tap_q   <= '0;
		end else begin
			case (state_q)
				SCAN_TAPS: begin
					if (stall) begin
						state_q <= SCAN_HOLD;
					end else if (tap_now.last) begin
						tap_q <= '0;
						// Advance to the next output position
						if (last_col) begin
							col_q <= '0;
							row_q <= row_q + 1'b1;
							if (last_row)
								state_q <= SCAN_IDLE;
						end else begin
							col_q <= col_q + 1'b1;
						end
					end else begin
						tap_q <= tap_q + 1'b1;
					end
				end
				SCAN_HOLD: begin
					if (!mac_busy_i)
						state_q <= SCAN_TAPS;
				end
				default: begin
					state_q <= SCAN_IDLE;
				end
			endcase
		end
	end

	// Tap info lines up with buffer read data
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			tap_q_d <= '0;
		else
			tap_q_d <= tap_now;
	end

	// --------------------
	// Layer completion
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			done_cnt_q   <= '0;
			layer_done_q <= 1'b0;
		end else if (start_i) begin
			done_cnt_q   <= '0;
			layer_done_q <= 1'b0;
		end else if (done_i) begin
			done_cnt_q <= done_cnt_q + 1'b1;
			// Last handshake of the frame
			if (done_cnt_q == pix_addr_t'(FRAME_SIZE - 1))
				layer_done_q <= 1'b1;
		end
	end

	assign rd_addr_o    = tap_now.addr;
	assign tap_o        = tap_q_d;
	assign layer_done_o = layer_done_q;

endmodule

//--- conv/conv_mac.sv
`timescale 1ns/10ps

module conv_mac
	import cnn_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  layer_cfg_t layer_cfg_i,
	input  tap_t       tap_i,
	input  pix_t       rd_data_i,
	// Four-phase sender side
	input  logic       out_ack_i,
	output logic       out_req_o,
	output pix_t       out_pix_o,
	output logic       mac_busy_o,
	// Pulse when a handshake completes
	output logic       done_o
);

	tap_idx_t tap_cnt_q, widx;
	acc_t     acc_q, acc_sum, prod;
	acc_t     post_in, biased, shifted;
	logic     acc_done_q;
	pix_t     res_pix, hold_q;
	logic     hold_full_q, req_q;
	logic     free_now, hold_blocked, res_ready, hold_load;

	// --------------------
	// Multiply-accumulate
	// --------------------
	// Weight index restarts on each first tap
	assign widx = tap_i.first ? '0 : tap_cnt_q;

	always_comb begin
		if (tap_i.pad)
			prod = '0;
		else
			prod = $signed({1'b0, rd_data_i}) * layer_cfg_i.weight[widx];
		acc_sum = (tap_i.first ? acc_t'(0) : acc_q) + prod;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			tap_cnt_q <= '0;
		else if (tap_i.vld)
			tap_cnt_q <= widx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (tap_i.vld)
			acc_q <= acc_sum;
	end

	// --------------------
	// Bias, shift, activation
	// --------------------
	// Parked sum takes priority over a live last tap
	assign post_in = acc_done_q ? acc_q : acc_sum;
	assign biased  = post_in + acc_t'($signed(layer_cfg_i.bias));
	assign shifted = biased >>> layer_cfg_i.shift;

	always_comb begin
		if (layer_cfg_i.act == ACT_RELU) begin
			if (shifted < 0)
				res_pix = 8'd0;
			else if (shifted > 255)
				res_pix = 8'd255;
			else
				res_pix = shifted[7:0];
		end else begin
			// Two's-complement byte, clamped
			if (shifted < -128)
				res_pix = 8'h80;
			else if (shifted > 127)
				res_pix = 8'h7f;
			else
				res_pix = shifted[7:0];
		end
	end

	// --------------------
	// Holding register and output handshake
	// --------------------
	// Sink has dropped ack after our req fell
	assign free_now     = hold_full_q && !req_q && !out_ack_i;
	assign hold_blocked = hold_full_q && !free_now;
	assign res_ready    = acc_done_q || (tap_i.vld && tap_i.last);
	assign hold_load    = res_ready && !hold_blocked;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			acc_done_q  <= 1'b0;
			hold_full_q <= 1'b0;
			req_q       <= 1'b0;
		end else begin
			// Park the finished sum while the holder is occupied
			if (tap_i.vld && tap_i.last && hold_blocked)
				acc_done_q <= 1'b1;
			else if (hold_load)
				acc_done_q <= 1'b0;
			if (hold_load)
				hold_full_q <= 1'b1;
			else if (free_now)
				hold_full_q <= 1'b0;
			if (hold_load)
				req_q <= 1'b1;
			else if (req_q && out_ack_i)
				req_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_load)
			hold_q <= res_pix;
	end

	assign out_req_o  = req_q;
	assign out_pix_o  = hold_q;
	assign mac_busy_o = hold_blocked && res_ready;
	assign done_o     = free_now;

endmodule

//--- design/cnn_accel_top.sv
`timescale 1ns/10ps

module cnn_accel_top
	import cnn_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	// Register write port
	input  logic        cfg_we_i,
	input  cfg_addr_t   cfg_addr_i,
	input  logic [31:0] cfg_wdata_i,
	// Pixel input handshake
	input  logic        pix_req_i,
	input  pix_t        pix_data_i,
	output logic        pix_ack_o,
	// Pixel output handshake
	output logic        out_req_o,
	output pix_t        out_pix_o,
	input  logic        out_ack_i,
	output logic        layer_done_o
);

	layer_cfg_t layer_cfg;
	logic       start;
	// Loader to buffer
	logic       wr_en;
	pix_addr_t  wr_addr;
	pix_t       wr_data;
	// Scanner and MAC
	pix_addr_t  rd_addr;
	pix_t       rd_data;
	tap_t       tap;
	logic       mac_busy;
	logic       out_done;

	cfg_regs u_cfg_regs (
		.clk         (clk),
		.rstn        (rstn),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.layer_cfg_o (layer_cfg),
		.start_o     (start)
	);

	pixel_loader u_pixel_loader (
		.clk        (clk),
		.rstn       (rstn),
		.pix_req_i  (pix_req_i),
		.pix_data_i (pix_data_i),
		.pix_ack_o  (pix_ack_o),
		.wr_en_o    (wr_en),
		.wr_addr_o  (wr_addr),
		.wr_data_o  (wr_data)
	);

	frame_buffer u_frame_buffer (
		.clk       (clk),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	window_scanner u_window_scanner (
		.clk          (clk),
		.rstn         (rstn),
		.start_i      (start),
		.mac_busy_i   (mac_busy),
		.done_i       (out_done),
		.rd_addr_o    (rd_addr),
		.tap_o        (tap),
		.layer_done_o (layer_done_o)
	);

	conv_mac u_conv_mac (
		.clk         (clk),
		.rstn        (rstn),
		.layer_cfg_i (layer_cfg),
		.tap_i       (tap),
		.rd_data_i   (rd_data),
		.out_ack_i   (out_ack_i),
		.out_req_o   (out_req_o),
		.out_pix_o   (out_pix_o),
		.mac_busy_o  (mac_busy),
		.done_o      (out_done)
	);

endmodule

//--- test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// --------------------
// Reference output pixel
// --------------------
// Raster index in, tap t sits at row offset t/3-1 and column offset t%3-1
function automatic pix_t ref_pixel(input int idx);
	int row;
	int col;
	int r;
	int c;
	int acc;
	int val;
	row = idx / FRAME_W;
	col = idx % FRAME_W;
	acc = 0;
	for (int t = 0; t < N_TAPS; t++) begin
		r = row + t / 3 - 1;
		c = col + t % 3 - 1;
		// Outside the frame counts as zero
		if (r >= 0 && r < FRAME_H && c >= 0 && c < FRAME_W)
			acc += int'(img_ref[r * FRAME_W + c]) * int'($signed(cfg_ref.weight[t]));
	end
	val = (acc + int'($signed(cfg_ref.bias))) >>> cfg_ref.shift;
	if (cfg_ref.act == ACT_LINEAR) begin
		if (val < -128)
			val = -128;
		else if (val > 127)
			val = 127;
	end else begin
		if (val < 0)
			val = 0;
		else if (val > 255)
			val = 255;
	end
	// Low byte, two's complement for linear
	return pix_t'(val & 255);
endfunction

// Galois LFSR, polynomial x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	else
		return s >> 1;
endfunction

// Compare and count
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_cnt++;
	if (got !== exp) begin
		mismatch_cnt++;
		$display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
	end
endtask

`endif

//--- test/tb_cnn_accel.sv
`timescale 1ns/10ps

module tb_cnn_accel
	import cnn_pkg::*;
();

	localparam int N_FRAMES   = 4;
	// Upper bound of 40 cycles per pixel and frame
	localparam int MAX_CYCLES = N_FRAMES * FRAME_SIZE * 40;

	logic        clk;
	logic        rstn;
	logic        cfg_we_i;
	cfg_addr_t   cfg_addr_i;
	logic [31:0] cfg_wdata_i;
	logic        pix_req_i;
	pix_t        pix_data_i;
	logic        pix_ack_o;
	logic        out_req_o;
	pix_t        out_pix_o;
	logic        out_ack_i;
	logic        layer_done_o;

	// Reference copy of image and layer setup
	pix_t        img_ref [FRAME_SIZE];
	layer_cfg_t  cfg_ref;
	logic [31:0] lfsr_q;
	int          check_cnt;
	int          mismatch_cnt;
	int          fail_cnt;
	// Outputs taken in the current frame
	int          out_cnt;
	int          ack_bits;
	logic        expect_copy;
	logic        hit_hi;
	logic        hit_lo;

	`include "tb_ref_model.svh"

	cnn_accel_top dut_i (
		.clk          (clk),
		.rstn         (rstn),
		.cfg_we_i     (cfg_we_i),
		.cfg_addr_i   (cfg_addr_i),
		.cfg_wdata_i  (cfg_wdata_i),
		.pix_req_i    (pix_req_i),
		.pix_data_i   (pix_data_i),
		.pix_ack_o    (pix_ack_o),
		.out_req_o    (out_req_o),
		.out_pix_o    (out_pix_o),
		.out_ack_i    (out_ack_i),
		.layer_done_o (layer_done_o)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Shifts in the LFSR low bit once per step
	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	// --------------------
	// Stimulus helpers
	// --------------------
	task automatic write_reg(input cfg_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		cfg_we_i    <= 1'b1;
		cfg_addr_i  <= addr;
		cfg_wdata_i <= data;
		@(posedge clk);
		cfg_we_i <= 1'b0;
	endtask

	// Full four-phase cycle on the pixel input
	task automatic send_pixel(input pix_t d);
		@(posedge clk);
		pix_req_i  <= 1'b1;
		pix_data_i <= d;
		do @(posedge clk); while (!pix_ack_o);
		pix_req_i <= 1'b0;
		do @(posedge clk); while (pix_ack_o);
	endtask

	task automatic load_config();
		for (int t = 0; t < N_TAPS; t++)
			write_reg(cfg_addr_t'(int'(REG_WEIGHT0) + t), {24'd0, cfg_ref.weight[t]});
		write_reg(REG_BIAS, {16'd0, cfg_ref.bias});
		// Activation in bit 8 and shift in bits 4:0
		write_reg(REG_LAYER, {23'd0, cfg_ref.act, 3'd0, cfg_ref.shift});
	endtask

	// Loads one frame and its setup, then runs the layer to the end
	task automatic run_frame(input int f);
		int wait_cnt;
		for (int i = 0; i < FRAME_SIZE; i++)
			img_ref[i] = pix_t'(take_bits(8));
		cfg_ref = '0;
		case (f)
			0: begin
				// Identity kernel
				cfg_ref.weight[4] = 8'sd1;
			end
			2: begin
				// Strong centre and small neighbours
				// Negative bias drives dark pixels below -128
				for (int t = 0; t < N_TAPS; t++)
					cfg_ref.weight[t] = weight_t'(int'(take_bits(3)) - 4);
				cfg_ref.weight[4] = 8'sd64;
				cfg_ref.bias      = -16'sd8000;
				cfg_ref.shift     = 5'd4;
				cfg_ref.act       = ACT_LINEAR;
			end
			default: begin
				for (int t = 0; t < N_TAPS; t++)
					cfg_ref.weight[t] = weight_t'(take_bits(8));
				cfg_ref.bias  = bias_t'(int'(take_bits(10)) - 512);
				cfg_ref.shift = shift_t'(take_bits(3) + 4);
				cfg_ref.act   = ACT_RELU;
			end
		endcase
		expect_copy = (f == 0);
		// Heavier back-pressure on the last frame
		ack_bits = (f == N_FRAMES - 1) ? 4 : 3;
		for (int i = 0; i < FRAME_SIZE; i++)
			send_pixel(img_ref[i]);
		load_config();
		out_cnt = 0;
		hit_hi  = 1'b0;
		hit_lo  = 1'b0;
		write_reg(REG_START, 32'd0);
		// Start clears the previous done flag
		repeat (2) @(posedge clk);
		check_value("layer_done_o", 32'(layer_done_o), 32'd0);
		while (out_cnt < FRAME_SIZE)
			@(posedge clk);
		wait_cnt = 0;
		while (!layer_done_o && wait_cnt < 16) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (!layer_done_o) begin
			$display("Error: layer_done_o did not rise after the last output of frame %0d", f);
			fail_cnt++;
		end
		// Collector flags any extra pixel in this window
		repeat (32) @(posedge clk);
		if (cfg_ref.act == ACT_LINEAR && !(hit_hi && hit_lo)) begin
			$display("Error: linear frame %0d did not reach both clamp limits", f);
			fail_cnt++;
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		rstn         = 1'b0;
		cfg_we_i     = 1'b0;
		cfg_addr_i   = '0;
		cfg_wdata_i  = '0;
		pix_req_i    = 1'b0;
		pix_data_i   = '0;
		out_ack_i    = 1'b0;
		lfsr_q       = 32'hdca8f8dd;
		check_cnt    = 0;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		out_cnt      = 0;
		ack_bits     = 3;
		expect_copy  = 1'b0;
		hit_hi       = 1'b0;
		hit_lo       = 1'b0;
		cfg_ref      = '0;
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		@(posedge clk);
		// Outputs idle out of reset
		check_value("pix_ack_o", 32'(pix_ack_o), 32'd0);
		check_value("out_req_o", 32'(out_req_o), 32'd0);
		check_value("layer_done_o", 32'(layer_done_o), 32'd0);
		for (int f = 0; f < N_FRAMES; f++)
			run_frame(f);
		$display("Checks %0d, mismatches %0d, other errors %0d",
			check_cnt, mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// --------------------
	// Output collector and sink
	// --------------------
	initial begin : collector
		int unsigned dly;
		pix_t        exp_pix;
		forever begin
			@(posedge clk);
			if (rstn && out_req_o) begin
				if (out_cnt >= FRAME_SIZE) begin
					$display("Error: output pixel arrived after the frame was complete");
					fail_cnt++;
				end else begin
					exp_pix = ref_pixel(out_cnt);
					check_value("out_pix_o", 32'(out_pix_o), 32'(exp_pix));
					if (expect_copy)
						check_value("out_pix_o", 32'(out_pix_o), 32'(img_ref[out_cnt]));
					// Not done before this handshake
					check_value("layer_done_o", 32'(layer_done_o), 32'd0);
					if (out_pix_o == 8'h7f)
						hit_hi = 1'b1;
					if (out_pix_o == 8'h80)
						hit_lo = 1'b1;
				end
				dly = take_bits(ack_bits);
				repeat (dly) @(posedge clk);
				out_ack_i <= 1'b1;
				do @(posedge clk); while (out_req_o);
				dly = take_bits(ack_bits);
				repeat (dly) @(posedge clk);
				// Still low until the sink releases ack
				check_value("layer_done_o", 32'(layer_done_o), 32'd0);
				out_ack_i <= 1'b0;
				out_cnt++;
			end
		end
	end

	// Watchdog
	initial begin
		repeat (MAX_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks %0d, mismatches %0d, other errors %0d",
			check_cnt, mismatch_cnt, fail_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
common/cnn_pkg.sv
design/cfg_regs.sv
design/pixel_loader.sv
design/frame_buffer.sv
conv/window_scanner.sv
conv/conv_mac.sv
design/cnn_accel_top.sv
test/tb_cnn_accel.sv

//--- Makefile
TOP := tb_cnn_accel

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir -o $(TOP)

# Pass only if the pass message shows up in the simulation output
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
